//--- hdl/fp27_defs.svh
// Constants of the 27-bit float format and its arithmetic unit
// Sign, 8-bit exponent with bias 127, 18-bit fraction with hidden one
`ifndef FP27_DEFS_SVH
`define FP27_DEFS_SVH

// Word layout
`define FP_W 27
`define FP_EXP_W 8
`define FP_FRAC_W 18

// Exponent of 1.0
`define FP_BIAS 8'd127

// Signed integer side of the conversions
`define FP_INT_W 16
`define FP_INT_MAX 16'd32767

// First estimate of 1/sqrt(x), bit trick on the raw word
`define FP_ISQRT_MAGIC 27'd49920718

// Encoding of 1.5 for the Newton step
`define FP_THREE_HALVES 27'd33423360

// Sampled request to registered result, in cycles
`define FP_LATENCY 4

`endif

//--- hdl/fp27_pkg.sv
// Types of the float unit
// One float word, the opcode, and the request and result bundles
`include "fp27_defs.svh"

package fp27_pkg;

   // Sign, biased exponent, fraction without hidden one
   typedef struct packed {
      logic                   sign;
      logic [`FP_EXP_W-1:0]   exp;
      logic [`FP_FRAC_W-1:0]  frac;
   } fp27_t;

   typedef enum logic [2:0] {
      OP_INT2FP = 3'd0,
      OP_FP2INT = 3'd1,
      OP_MUL    = 3'd2,
      OP_ADD    = 3'd3,
      OP_ISQRT  = 3'd4
   } fp_op_e;

   // One request, all operand fields present for every opcode
   typedef struct packed {
      fp_op_e                op;
      fp27_t                 a;
      fp27_t                 b;
      logic [`FP_INT_W-1:0]  int_in;
   } fp_req_t;

   // Field not belonging to the opcode stays zero
   typedef struct packed {
      fp27_t                 fp_out;
      logic [`FP_INT_W-1:0]  int_out;
   } fp_rsp_t;

endpackage

//--- hdl/fp_int_convert.sv
// Integer and float conversion, combinational
// Signed 16-bit integer to float, and float to saturating 16-bit integer
`timescale 1ns/10ps
`include "fp27_defs.svh"

module fp_int_convert
   import fp27_pkg::*;
(
   input  logic signed [`FP_INT_W-1:0] int_in,
   input  fp27_t                       a,
   output fp27_t                       fp_out,
   output logic signed [`FP_INT_W-1:0] int_out
);

   // Integer to float
   logic                   i2f_neg;
   logic [`FP_INT_W-1:0]   i2f_mag;
   logic [3:0]             lead;
   logic [33:0]            i2f_buf;
   logic [`FP_EXP_W-1:0]   i2f_exp;

   // Float to integer
   logic [`FP_EXP_W-1:0]   unb_exp;
   logic [33:0]            f2i_buf;
   logic [`FP_INT_W-1:0]   f2i_mag;

   assign i2f_neg = int_in[`FP_INT_W-1];
   // -32768 comes out as 0x8000, still a valid magnitude
   assign i2f_mag = i2f_neg ? -int_in : int_in;

   // Priority encoder, highest set bit wins
   always_comb begin
      lead = 4'd0;
      for (int i = 0; i < `FP_INT_W; i++) begin
         if (i2f_mag[i]) lead = i[3:0];
      end
   end

   // Leading one lands on bit 18, the hidden position
   assign i2f_buf = {18'b0, i2f_mag} << (5'd18 - {1'b0, lead});
   assign i2f_exp = `FP_BIAS + {4'b0, lead};
   assign fp_out  = (int_in == '0) ? '0 : {i2f_neg, i2f_exp, i2f_buf[17:0]};

   // Hidden one at bit 18, integer part ends up in the top 16 bits
   assign unb_exp = a.exp - `FP_BIAS;
   assign f2i_buf = {15'b0, 1'b1, a.frac} << unb_exp;
   assign f2i_mag = f2i_buf[33:18];

   always_comb begin
      if (a.exp < `FP_BIAS) begin
         // Magnitude below one truncates to zero
         int_out = '0;
      end else if (unb_exp > 8'd14) begin
         int_out = a.sign ? -`FP_INT_MAX : `FP_INT_MAX;
      end else begin
         int_out = a.sign ? -f2i_mag : f2i_mag;
      end
   end

endmodule

//--- hdl/fp_mul.sv
// Float multiplier, combinational
// Drops the lowest fraction bit of each operand, flushes underflow to zero
`timescale 1ns/10ps
`include "fp27_defs.svh"

module fp_mul
   import fp27_pkg::*;
(
   input  fp27_t a,
   input  fp27_t b,
   output fp27_t prod
);

   logic [`FP_FRAC_W-1:0]   man_a;
   logic [`FP_FRAC_W-1:0]   man_b;
   logic [2*`FP_FRAC_W-1:0] man_p;
   logic [`FP_EXP_W:0]      exp_sum;
   logic [`FP_EXP_W:0]      exp_p;
   logic [`FP_FRAC_W-1:0]   frac_p;
   logic                    underflow;

   // Hidden one on top, fraction LSB falls off
   assign man_a = {1'b1, a.frac[`FP_FRAC_W-1:1]};
   assign man_b = {1'b1, b.frac[`FP_FRAC_W-1:1]};
   assign man_p = man_a * man_b;

   // Both biases in the sum, one taken back below
   assign exp_sum = {1'b0, a.exp} + {1'b0, b.exp};

   // Product in [1,4), one step of normalization
   assign exp_p  = man_p[35] ? exp_sum - {1'b0, `FP_BIAS} + 9'd1
                             : exp_sum - {1'b0, `FP_BIAS};
   assign frac_p = man_p[35] ? man_p[34:17] : man_p[33:16];

   assign underflow = exp_sum < 9'd128;

   always_comb begin
      if (underflow || a.exp == '0 || b.exp == '0) begin
         prod = '0;
      end else begin
         prod = {a.sign ^ b.sign, exp_p[`FP_EXP_W-1:0], frac_p};
      end
   end

endmodule

//--- hdl/fp_add.sv
// Float adder, two stages
// Stage one aligns and adds, stage two normalizes after the register
`timescale 1ns/10ps
`include "fp27_defs.svh"

module fp_add
   import fp27_pkg::*;
(
   input  logic  iCLK,
   input  fp27_t a,
   input  fp27_t b,
   output fp27_t sum
);

   logic [`FP_FRAC_W-1:0] man_a;
   logic [`FP_FRAC_W-1:0] man_b;
   logic                  a_larger;
   logic [`FP_EXP_W-1:0]  exp_diff;
   logic [`FP_EXP_W-1:0]  big_exp;
   logic [36:0]           big_al;
   logic [36:0]           small_al;
   logic [36:0]           raw;

   // Stage one registers
   logic [36:0]           raw_q;
   logic [`FP_EXP_W-1:0]  exp_q;
   logic                  sign_q;
   logic                  a_zero_q;
   logic                  b_zero_q;
   fp27_t                 a_q;
   fp27_t                 b_q;

   // Stage two
   logic [5:0]            shft;
   logic [53:0]           norm;
   logic [`FP_EXP_W-1:0]  exp_n;
   logic                  exp_uflow;

   assign man_a = {1'b1, a.frac[`FP_FRAC_W-1:1]};
   assign man_b = {1'b1, b.frac[`FP_FRAC_W-1:1]};

   // Magnitude compare, exponent first
   assign a_larger = (a.exp > b.exp) || ((a.exp == b.exp) && (man_a > man_b));
   assign exp_diff = a_larger ? a.exp - b.exp : b.exp - a.exp;
   assign big_exp  = a_larger ? a.exp : b.exp;

   // One guard bit on top for the carry, 18 extra below for shifted-out bits
   assign big_al   = {1'b0, a_larger ? man_a : man_b, 18'b0};
   assign small_al = (exp_diff > 8'd35) ? '0
                   : {1'b0, a_larger ? man_b : man_a, 18'b0} >> exp_diff;

   // Smaller always subtracted from larger, no negative result
   assign raw = (a.sign ^ b.sign) ? big_al - small_al : big_al + small_al;

   always_ff @(posedge iCLK) begin
      raw_q    <= raw;
      exp_q    <= big_exp;
      sign_q   <= a_larger ? a.sign : b.sign;
      a_zero_q <= (a.exp == '0);
      b_zero_q <= (b.exp == '0);
      a_q      <= a;
      b_q      <= b;
   end

   // Leading-one encoder over 37 bits, 37 means no bit set
   always_comb begin
      shft = 6'd37;
      for (int i = 0; i < 37; i++) begin
         if (raw_q[i]) shft = 6'(36 - i);
      end
   end

   // Leading one moved to bit 53 and dropped as the hidden one
   assign norm  = {raw_q, 17'b0} << shft;
   assign exp_n = exp_q - {2'b0, shft} + 8'd1;

   // Result exponent would reach zero or below
   assign exp_uflow = ({1'b0, exp_q} + 9'd1) <= {3'b0, shft};

   always_comb begin
      if (a_zero_q && b_zero_q) begin
         sum = '0;
      end else if (a_zero_q) begin
         sum = b_q;
      end else if (b_zero_q) begin
         sum = a_q;
      end else if (raw_q == '0 || exp_uflow) begin
         // Cancellation or underflow
         sum = '0;
      end else begin
         sum = {sign_q, exp_n, norm[52:35]};
      end
   end

endmodule

//--- hdl/fp_inv_sqrt.sv
// Fast inverse square root, pipelined over four clock edges
// Magic-constant estimate y, then one Newton step y*(1.5 - x/2*y*y)
`timescale 1ns/10ps
`include "fp27_defs.svh"

module fp_inv_sqrt
   import fp27_pkg::*;
(
   input  logic  iCLK,
   input  fp27_t a,
   output fp27_t inv_sqrt
);

   // Before edge 1
   fp27_t y1;
   fp27_t half_a1;
   fp27_t ysq1;

   // After edge 1
   fp27_t y2;
   fp27_t ysq2;
   fp27_t half_a2;
   fp27_t hy2;

   // After edge 2
   fp27_t y3;
   fp27_t hy3;
   fp27_t neg_hy3;
   fp27_t corr;

   // After edges 3 and 4
   fp27_t y4;
   fp27_t y5;
   fp27_t corr5;

   // Estimate straight from the raw bits
   assign y1 = `FP_ISQRT_MAGIC - (a >> 1);

   // Halving is one off the exponent
   assign half_a1 = {a.sign, a.exp - 8'd1, a.frac};

   fp_mul sq_mul (.a(y1), .b(y1), .prod(ysq1));

   fp_mul hy_mul (.a(half_a2), .b(ysq2), .prod(hy2));

   // 1.5 - x/2*y*y, registered inside the adder at edge 3
   assign neg_hy3 = {~hy3.sign, hy3.exp, hy3.frac};
   fp_add corr_add (.iCLK(iCLK), .a(neg_hy3), .b(`FP_THREE_HALVES), .sum(corr));

   fp_mul out_mul (.a(y5), .b(corr5), .prod(inv_sqrt));

   always_ff @(posedge iCLK) begin
      // Edge 1
      y2      <= y1;
      ysq2    <= ysq1;
      half_a2 <= half_a1;
      // Edge 2
      y3      <= y2;
      hy3     <= hy2;
      // Edge 3, y waits while the adder works
      y4      <= y3;
      // Edge 4
      y5      <= y4;
      corr5   <= corr;
   end

endmodule

//--- hdl/fp_unit.sv
// Float arithmetic unit, top level
// All units run in parallel on each request, results line up after
// four cycles and the one matching the opcode is registered out
`timescale 1ns/10ps
`include "fp27_defs.svh"

module fp_unit
   import fp27_pkg::*;
(
   input  logic    iCLK,
   input  logic    rst,
   input  logic    in_valid,
   input  fp_req_t req,
   output logic    out_valid,
   output fp_rsp_t rsp
);

   // Request payload taken at the sampling edge
   fp_req_t                req_q;

   // Stage 0 sits beside req_q, stage 3 feeds the output register
   logic [`FP_LATENCY-1:0] vld_pipe;
   fp_op_e                 op_pipe [`FP_LATENCY];

   // Raw unit results
   fp27_t                  i2f_res;
   logic [`FP_INT_W-1:0]   f2i_res;
   fp27_t                  mul_res;
   fp27_t                  add_res;
   fp27_t                  isqrt_res;

   // Delay lines
   fp27_t                  i2f_d [3];
   logic [`FP_INT_W-1:0]   f2i_d [3];
   fp27_t                  mul_d [3];
   fp27_t                  add_d [2];

   fp_rsp_t                rsp_next;

   fp_int_convert conv0 (
      .int_in  (req_q.int_in),
      .a       (req_q.a),
      .fp_out  (i2f_res),
      .int_out (f2i_res)
   );

   fp_mul mul0 (.a(req_q.a), .b(req_q.b), .prod(mul_res));

   fp_add add0 (.iCLK(iCLK), .a(req_q.a), .b(req_q.b), .sum(add_res));

   // Longest unit, fed before the request register so it lands on time
   fp_inv_sqrt isqrt0 (.iCLK(iCLK), .a(req.a), .inv_sqrt(isqrt_res));

   always_ff @(posedge iCLK) begin
      req_q    <= req;
      i2f_d[0] <= i2f_res;
      f2i_d[0] <= f2i_res;
      mul_d[0] <= mul_res;
      add_d[0] <= add_res;
      for (int i = 1; i < 3; i++) begin
         i2f_d[i] <= i2f_d[i-1];
         f2i_d[i] <= f2i_d[i-1];
         mul_d[i] <= mul_d[i-1];
      end
      add_d[1] <= add_d[0];
   end

   // Valid and opcode follow the payload
   always_ff @(posedge iCLK) begin
      if (rst) begin
         vld_pipe <= '0;
         for (int i = 0; i < `FP_LATENCY; i++) begin
            op_pipe[i] <= OP_INT2FP;
         end
      end else begin
         vld_pipe   <= {vld_pipe[`FP_LATENCY-2:0], in_valid};
         op_pipe[0] <= req.op;
         for (int i = 1; i < `FP_LATENCY; i++) begin
            op_pipe[i] <= op_pipe[i-1];
         end
      end
   end

   // Pick by opcode, other field left at zero
   always_comb begin
      rsp_next = '0;
      case (op_pipe[`FP_LATENCY-1])
         OP_INT2FP: rsp_next.fp_out  = i2f_d[2];
         OP_FP2INT: rsp_next.int_out = f2i_d[2];
         OP_MUL:    rsp_next.fp_out  = mul_d[2];
         OP_ADD:    rsp_next.fp_out  = add_d[1];
         OP_ISQRT:  rsp_next.fp_out  = isqrt_res;
         default:   rsp_next = '0;
      endcase
   end

   // Result holds between pulses
   always_ff @(posedge iCLK) begin
      if (rst) begin
         out_valid <= 1'b0;
         rsp       <= '0;
      end else begin
         out_valid <= vld_pipe[`FP_LATENCY-1];
         if (vld_pipe[`FP_LATENCY-1]) begin
            rsp <= rsp_next;
         end
      end
   end

endmodule

//--- verification/fp_unit_assertions.sv
// Protocol checks on the float unit top level
// Quiet output around reset, fixed pulse latency, no unknown result bits
`timescale 1ns/10ps
`include "fp27_defs.svh"

module fp_unit_assertions
   import fp27_pkg::*;
(
   input logic    iCLK,
   input logic    rst,
   input logic    in_valid,
   input logic    out_valid,
   input fp_rsp_t rsp
);

   // Output register cleared on every reset edge
   reset_quiet: assert property (@(posedge iCLK) rst |=> !out_valid)
      else $error("out_valid high during reset");

   // Valid pipeline still empty on the first cycle out of reset
   after_reset_quiet: assert property (@(posedge iCLK) $fell(rst) |=> !out_valid)
      else $error("out_valid high on the cycle after reset");

   // Sampled at E, registered at E+4, seen at the edge after
   fixed_latency: assert property (@(posedge iCLK) disable iff (rst)
      out_valid == $past(in_valid, `FP_LATENCY + 1))
      else $error("out_valid does not follow in_valid by the fixed latency");

   known_result: assert property (@(posedge iCLK) out_valid |-> !$isunknown(rsp))
      else $error("rsp carries unknown bits while out_valid is high");

endmodule

bind fp_unit fp_unit_assertions fp_unit_chk (
   .iCLK      (iCLK),
   .rst       (rst),
   .in_valid  (in_valid),
   .out_valid (out_valid),
   .rsp       (rsp)
);

//--- verification/fp_unit_tb.sv
// Testbench for the 27-bit float unit
// Directed tests per opcode and a mixed burst with results checked in request order
`timescale 1ns/10ps
`include "fp27_defs.svh"

module fp_unit_tb
   import fp27_pkg::*;
();

   localparam int CLK_PERIOD = 20;
   // Upper bound on requests over all tests
   localparam int REQ_BUDGET = 200;

   logic        iCLK = 1'b0;
   logic        rst;
   logic        in_valid;
   fp_req_t     req;
   logic        out_valid;
   fp_rsp_t     rsp;

   // Outstanding requests with the oldest in front
   fp_rsp_t     exp_q [$];
   bit          approx_q [$];
   int          stamp_q [$];
   int          int_pool [$];
   int          cyc = 0;
   logic [31:0] lfsr = 32'h786f;

   fp_unit dut0 (
      .iCLK      (iCLK),
      .rst       (rst),
      .in_valid  (in_valid),
      .req       (req),
      .out_valid (out_valid),
      .rsp       (rsp)
   );

   always #(CLK_PERIOD / 2) iCLK = ~iCLK;

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[14:0], lfsr[0]};
      end
   endtask

   // Sign plus 7-bit magnitude
   task automatic take_small(output int v);
      logic [15:0] r;
      take_bits(8, r);
      v = int'(r[6:0]);
      if (r[7]) begin
         v = -v;
      end
   endtask

   // Leading one at p sets exponent bias+p with the bits below it left-aligned in the fraction
   function automatic fp27_t encode_int(input int v);
      int    mag;
      int    p;
      fp27_t f;
      mag = (v < 0) ? -v : v;
      p = 0;
      while ((mag >> (p + 1)) != 0) begin
         p++;
      end
      f.sign = (v < 0);
      f.exp  = 8'(`FP_BIAS + p);
      f.frac = 18'((mag - (1 << p)) << (`FP_FRAC_W - p));
      return (v == 0) ? '0 : f;
   endfunction

   function automatic real fp_to_real(input fp27_t f);
      real r;
      int  e;
      r = 1.0 + real'(f.frac) / 262144.0;
      e = int'(f.exp) - 127;
      for (int i = 0; i < e; i++) begin
         r = r * 2.0;
      end
      for (int i = 0; i > e; i--) begin
         r = r / 2.0;
      end
      if (f.sign) begin
         r = -r;
      end
      return (f.exp == '0) ? 0.0 : r;
   endfunction

   function automatic fp_rsp_t float_result(input fp27_t f);
      fp_rsp_t r;
      r = '0;
      r.fp_out = f;
      return r;
   endfunction

   function automatic fp_rsp_t int_result(input int v);
      fp_rsp_t r;
      r = '0;
      r.int_out = 16'(v);
      return r;
   endfunction

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
      if (got !== want) begin
         $display("FAIL t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, want);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   task automatic stop_with_error(input string why);
      $display("ERROR t=%0t %s", $time, why);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   // One request on the next edge with the strobe left high for back-to-back use
   task automatic send(input fp_op_e op, input fp27_t a, input fp27_t b,
                       input logic [15:0] iv, input fp_rsp_t want, input bit approx);
      @(posedge iCLK);
      in_valid   <= 1'b1;
      req.op     <= op;
      req.a      <= a;
      req.b      <= b;
      req.int_in <= iv;
      exp_q.push_back(want);
      approx_q.push_back(approx);
   endtask

   task automatic drain();
      @(posedge iCLK);
      in_valid <= 1'b0;
      while (exp_q.size() != 0) begin
         @(posedge iCLK);
      end
   endtask

   // Pulses compared against the oldest request
   always @(posedge iCLK) begin
      fp_rsp_t want;
      bit      approx;
      int      stamp;
      real     got;
      real     ideal;
      cyc <= cyc + 1;
      if (!rst && in_valid) begin
         stamp_q.push_back(cyc);
      end
      if (out_valid) begin
         if (exp_q.size() == 0 || stamp_q.size() == 0) begin
            stop_with_error("out_valid pulsed with no request outstanding");
         end else begin
            want   = exp_q.pop_front();
            approx = approx_q.pop_front();
            stamp  = stamp_q.pop_front();
            // Registered FP_LATENCY edges after sampling and seen one edge later
            check("out_valid latency", 64'(cyc - stamp), 64'(`FP_LATENCY + 1));
            if (!approx) begin
               check("rsp", 64'(rsp), 64'(want));
            end else begin
               check("rsp.int_out", 64'(rsp.int_out), 64'd0);
               got   = fp_to_real(rsp.fp_out);
               ideal = fp_to_real(want.fp_out);
               // Tolerance of 0.5% around the exact power of two
               if (got < ideal * 0.995 || got > ideal * 1.005) begin
                  check("rsp.fp_out", 64'(rsp.fp_out), 64'(want.fp_out));
               end
            end
         end
      end
   end

   task automatic reset_idle_check();
      repeat (8) begin
         @(posedge iCLK);
         check("out_valid", 64'(out_valid), 64'd0);
      end
      send(OP_INT2FP, '0, '0, 16'd5, float_result(encode_int(5)), 1'b0);
      drain();
   endtask

   task automatic convert_int_to_float();
      int          vals [6] = '{0, 1, -1, 32767, -32767, -32768};
      int          v;
      logic [15:0] r;
      foreach (vals[i]) begin
         int_pool.push_back(vals[i]);
      end
      for (int i = 0; i < 40; i++) begin
         take_bits(16, r);
         v = int'($signed(r));
         int_pool.push_back(v);
      end
      foreach (int_pool[i]) begin
         v = int_pool[i];
         send(OP_INT2FP, '0, '0, 16'(v), float_result(encode_int(v)), 1'b0);
      end
      drain();
   endtask

   task automatic convert_float_to_int();
      int v;
      foreach (int_pool[i]) begin
         v = int_pool[i];
         // -32768 sits at unbiased exponent 15 and saturates
         send(OP_FP2INT, encode_int(v), '0, '0, int_result((v < -32767) ? -32767 : v), 1'b0);
      end
      send(OP_FP2INT, {1'b0, 8'd126, 18'h3ffff}, '0, '0, int_result(0), 1'b0);
      send(OP_FP2INT, {1'b1, 8'd100, 18'h12345}, '0, '0, int_result(0), 1'b0);
      // 1.5 * 2 and -1.99.. * 8 truncated toward zero
      send(OP_FP2INT, {1'b0, 8'd128, 18'h20000}, '0, '0, int_result(3), 1'b0);
      send(OP_FP2INT, {1'b1, 8'd130, 18'h3ffff}, '0, '0, int_result(-15), 1'b0);
      send(OP_FP2INT, {1'b0, 8'd142, 18'h00000}, '0, '0, int_result(32767), 1'b0);
      send(OP_FP2INT, {1'b1, 8'd147, 18'h2aaaa}, '0, '0, int_result(-32767), 1'b0);
      drain();
   endtask

   task automatic multiply_pairs();
      int x;
      int y;
      for (int i = 0; i < 20; i++) begin
         take_small(x);
         take_small(y);
         send(OP_MUL, encode_int(x), encode_int(y), '0, float_result(encode_int(x * y)), 1'b0);
      end
      drain();
   endtask

   task automatic add_pairs();
      int x;
      int y;
      for (int i = 0; i < 20; i++) begin
         take_small(x);
         take_small(y);
         send(OP_ADD, encode_int(x), encode_int(y), '0, float_result(encode_int(x + y)), 1'b0);
      end
      // Zero operands pass the other word through
      send(OP_ADD, '0, {1'b0, 8'd130, 18'h12345}, '0, float_result({1'b0, 8'd130, 18'h12345}),
           1'b0);
      send(OP_ADD, encode_int(-91), '0, '0, float_result(encode_int(-91)), 1'b0);
      send(OP_ADD, '0, '0, '0, float_result('0), 1'b0);
      send(OP_ADD, encode_int(45), encode_int(-45), '0, float_result('0), 1'b0);
      send(OP_ADD, encode_int(64), encode_int(-1), '0, float_result(encode_int(63)), 1'b0);
      drain();
   endtask

   // 1/sqrt(4^k) is 2^-k
   task automatic inv_sqrt_powers();
      for (int k = 0; k <= 6; k++) begin
         send(OP_ISQRT, {1'b0, 8'(127 + 2 * k), 18'd0}, '0, '0,
              float_result({1'b0, 8'(127 - k), 18'd0}), 1'b1);
      end
      drain();
   endtask

   task automatic mixed_burst();
      int x;
      int y;
      int k;
      for (int i = 0; i < 12; i++) begin
         take_small(x);
         take_small(y);
         k = i % 4;
         case (i % 5)
            0: send(OP_INT2FP, '0, '0, 16'(x * 200), float_result(encode_int(x * 200)), 1'b0);
            1: send(OP_FP2INT, encode_int(x * 200), '0, '0, int_result(x * 200), 1'b0);
            2: send(OP_MUL, encode_int(x), encode_int(y), '0, float_result(encode_int(x * y)),
                    1'b0);
            3: send(OP_ADD, encode_int(x), encode_int(y), '0, float_result(encode_int(x + y)),
                    1'b0);
            default: send(OP_ISQRT, {1'b0, 8'(127 + 2 * k), 18'd0}, '0, '0,
                          float_result({1'b0, 8'(127 - k), 18'd0}), 1'b1);
         endcase
      end
      drain();
   endtask

   initial begin
      #((REQ_BUDGET * (`FP_LATENCY + 4) + 100) * CLK_PERIOD);
      stop_with_error("watchdog expired before the tests finished");
   end

   initial begin
      rst      = 1'b1;
      in_valid = 1'b0;
      req      = '0;
      repeat (3) @(posedge iCLK);
      rst <= 1'b0;
      reset_idle_check();
      convert_int_to_float();
      convert_float_to_int();
      multiply_pairs();
      add_pairs();
      inv_sqrt_powers();
      mixed_burst();
      // Idle tail so a stray late pulse still reaches the monitor
      repeat (4) @(posedge iCLK);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

//--- fp_unit.f
+incdir+hdl
hdl/fp27_pkg.sv
hdl/fp_int_convert.sv
hdl/fp_mul.sv
hdl/fp_add.sv
hdl/fp_inv_sqrt.sv
hdl/fp_unit.sv
verification/fp_unit_assertions.sv
verification/fp_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the float unit testbench with Verilator, run it, check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module fp_unit_tb -f fp_unit.f -o fp_unit_sim

./obj_dir/fp_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
